// File: panel_pkg.sv
package panel_pkg;

    // panel geometry, scanned as two halves
    localparam int COL_BITS  = 6;
    localparam int COLS      = 1 << COL_BITS;
    localparam int ROW_BITS  = 5;                // row pair index
    localparam int ROW_PAIRS = 1 << ROW_BITS;

    // frame buffer word address is {row pair, column}
    localparam int FB_ADDR_BITS = ROW_BITS + COL_BITS;

    // pwm subframe counter
    localparam int SUBFRAME_BITS = 8;

    // 5-6-5 pixel, red in the top bits
    localparam int RED_BITS   = 5;
    localparam int GREEN_BITS = 6;
    localparam int BLUE_BITS  = 5;
    localparam int PIXEL_BITS = RED_BITS + GREEN_BITS + BLUE_BITS;

    localparam logic [PIXEL_BITS-1:0] PIXEL_WHITE = '1;
    localparam logic [PIXEL_BITS-1:0] PIXEL_BLACK = '0;

    localparam int CURSOR_START = 32;            // both x and y

    // button commands, codes match the move vectors
    typedef enum logic [1:0] {
        CMD_NONE    = 2'd0,
        CMD_FORWARD = 2'd1,
        CMD_LEFT    = 2'd2,
        CMD_RIGHT   = 2'd3
    } move_cmd_e;

endpackage

// File: move_decode.sv
module move_decode (
    input  logic                 clk,
    input  logic                 pll_locked,
    input  logic                 forward,
    input  logic                 left,
    input  logic                 right,
    input  logic                 steal,
    input  logic                 ready,
    output panel_pkg::move_cmd_e cmd
);
    import panel_pkg::*;

    logic await_release;    // a command went out, wait for all buttons up
    logic any_pressed;
    logic take;

    assign any_pressed = forward | left | right;
    assign take        = steal & ready & ~await_release & any_pressed;

    // forward wins over left, left over right
    always_comb begin
        cmd = CMD_NONE;
        if (take) begin
            if (forward) begin
                cmd = CMD_FORWARD;
            end else if (left) begin
                cmd = CMD_LEFT;
            end else begin
                cmd = CMD_RIGHT;
            end
        end
    end

    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            await_release <= 1'b0;
        end else if (take) begin
            await_release <= 1'b1;
        end else if (steal && !any_pressed) begin
            await_release <= 1'b0;  // release only counts in a stolen subframe
        end
    end

    // a command lives one cycle and only inside a stolen subframe
    a_cmd_in_steal : assert property (@(posedge clk) disable iff (!pll_locked)
        (cmd != CMD_NONE) |-> steal ##1 (cmd == CMD_NONE));

endmodule

// File: cursor_engine.sv
module cursor_engine (
    input  logic                                 clk,
    input  logic                                 pll_locked,
    input  logic                                 steal,
    input  panel_pkg::move_cmd_e                 cmd,
    output logic                                 ready,
    output logic                                 wr_en,
    output logic                                 wr_bank,
    output logic                                 clear_all,
    output logic [panel_pkg::FB_ADDR_BITS-1:0]   wr_addr,
    output logic [panel_pkg::PIXEL_BITS-1:0]     wr_data
);
    import panel_pkg::*;

    typedef enum logic [2:0] {
        ST_CLEAR,       // startup sweep over all addresses
        ST_IDLE,
        ST_CLEAR_OLD,
        ST_UPDATE,
        ST_SET_NEW
    } engine_state_e;

    engine_state_e           state;
    move_cmd_e               pending;   // command taken in idle
    logic [FB_ADDR_BITS-1:0] clr_addr;
    logic [COL_BITS-1:0]     cur_x;
    logic [ROW_BITS:0]       cur_y;     // full 64 rows with the msb picking the bank
    logic signed [1:0]       dx;
    logic signed [1:0]       dy;

    assign ready     = (state == ST_IDLE);
    assign clear_all = steal && (state == ST_CLEAR);
    assign wr_en     = steal && (state == ST_CLEAR || state == ST_CLEAR_OLD ||
                                 state == ST_SET_NEW);
    assign wr_addr   = (state == ST_CLEAR) ? clr_addr : {cur_y[ROW_BITS-1:0], cur_x};
    assign wr_bank   = cur_y[ROW_BITS];
    assign wr_data   = (state == ST_SET_NEW) ? PIXEL_WHITE : PIXEL_BLACK;

    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            state    <= ST_CLEAR;
            pending  <= CMD_NONE;
            clr_addr <= '0;
            cur_x    <= COL_BITS'(CURSOR_START);
            cur_y    <= (ROW_BITS + 1)'(CURSOR_START);
            dx       <= 2'sd1;  // heading +x
            dy       <= 2'sd0;
        end else if (steal) begin   // frozen outside stolen subframes
            case (state)
                ST_CLEAR: begin
                    clr_addr <= clr_addr + 1'b1;
                    if (clr_addr == '1) begin
                        state <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    if (cmd != CMD_NONE) begin
                        pending <= cmd;
                        state   <= ST_CLEAR_OLD;
                    end
                end
                ST_CLEAR_OLD: state <= ST_UPDATE;
                ST_UPDATE: begin
                    case (pending)
                        CMD_FORWARD: begin  // wraps mod 64 on both axes
                            cur_x <= cur_x + {{(COL_BITS - 2){dx[1]}}, dx};
                            cur_y <= cur_y + {{(ROW_BITS - 1){dy[1]}}, dy};
                        end
                        CMD_LEFT: begin     // ccw
                            dx <= -dy;
                            dy <= dx;
                        end
                        CMD_RIGHT: begin    // cw
                            dx <= dy;
                            dy <= -dx;
                        end
                        default: ;
                    endcase
                    state <= ST_SET_NEW;
                end
                ST_SET_NEW: state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    // memory and cursor only change while the scan shows black
    a_wr_in_steal : assert property (@(posedge clk) disable iff (!pll_locked)
        !steal |-> !wr_en ##1 $stable({state, pending, clr_addr, cur_x, cur_y, dx, dy}));

endmodule

// File: frame_buffer.sv
module frame_buffer (
    input  logic                               clk,
    input  logic [panel_pkg::FB_ADDR_BITS-1:0] scan_addr,
    output logic [panel_pkg::PIXEL_BITS-1:0]   rd_top,
    output logic [panel_pkg::PIXEL_BITS-1:0]   rd_bottom,
    input  logic                               wr_en,
    input  logic                               wr_bank,
    input  logic                               clear_all,
    input  logic [panel_pkg::FB_ADDR_BITS-1:0] wr_addr,
    input  logic [panel_pkg::PIXEL_BITS-1:0]   wr_data
);
    import panel_pkg::*;

    localparam int DEPTH = ROW_PAIRS * COLS;

    logic [PIXEL_BITS-1:0] rd_q [2];    // bank 0 top half, bank 1 bottom half

    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic [PIXEL_BITS-1:0] mem [DEPTH];
        logic                  sel;

        // clear_all hits both banks at once
        assign sel = wr_en && (clear_all || wr_bank == 1'(b));

        always_ff @(posedge clk) begin
            if (sel) begin
                mem[wr_addr] <= wr_data;
            end
            rd_q[b] <= mem[scan_addr];  // registered read
        end
    end

    assign rd_top    = rd_q[0];
    assign rd_bottom = rd_q[1];

endmodule

// File: pixel_pwm.sv
module pixel_pwm (
    input  logic [panel_pkg::SUBFRAME_BITS-1:0] subframe,
    input  logic                                steal,
    input  logic [panel_pkg::PIXEL_BITS-1:0]    rd_top,
    input  logic [panel_pkg::PIXEL_BITS-1:0]    rd_bottom,
    output logic [2:0]                          pwm_top,
    output logic [2:0]                          pwm_bottom
);
    import panel_pkg::*;

    logic [SUBFRAME_BITS-1:0] threshold;

    // bit reversed subframe spreads the on time, less flicker
    always_comb begin
        for (int i = 0; i < SUBFRAME_BITS; i++) begin
            threshold[i] = subframe[SUBFRAME_BITS-1-i];
        end
    end

    // {blue, green, red} on bits for one 5-6-5 pixel
    function automatic logic [2:0] channel_bits(input logic [PIXEL_BITS-1:0] px,
                                                input logic [SUBFRAME_BITS-1:0] thr);
        logic [SUBFRAME_BITS-1:0] r8;
        logic [SUBFRAME_BITS-1:0] g8;
        logic [SUBFRAME_BITS-1:0] b8;
        r8 = {px[PIXEL_BITS-1 -: RED_BITS], {(SUBFRAME_BITS - RED_BITS){1'b0}}};
        g8 = {px[BLUE_BITS +: GREEN_BITS], {(SUBFRAME_BITS - GREEN_BITS){1'b0}}};
        b8 = {px[0 +: BLUE_BITS], {(SUBFRAME_BITS - BLUE_BITS){1'b0}}};
        return {b8 > thr, g8 > thr, r8 > thr};
    endfunction

    assign pwm_top    = steal ? 3'b000 : channel_bits(rd_top, threshold);
    assign pwm_bottom = steal ? 3'b000 : channel_bits(rd_bottom, threshold);

endmodule

// File: panel_scan.sv
module panel_scan #(
    parameter int STEAL_BITS = 4
) (
    input  logic                                clk,
    input  logic                                pll_locked,
    input  logic [2:0]                          pwm_top,
    input  logic [2:0]                          pwm_bottom,
    output logic [panel_pkg::FB_ADDR_BITS-1:0]  scan_addr,
    output logic [panel_pkg::SUBFRAME_BITS-1:0] subframe,
    output logic                                steal,
    output logic [2:0]                          rgb_top,
    output logic [2:0]                          rgb_bottom,
    output logic [panel_pkg::ROW_BITS-1:0]      row_addr,
    output logic                                blank,
    output logic                                latch,
    output logic                                sclk
);
    import panel_pkg::*;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_SHIFT,
        ST_LATCH,
        ST_UNBLANK
    } scan_state_e;

    scan_state_e         state;
    logic [COL_BITS-1:0] col;       // column being read
    logic [ROW_BITS-1:0] row;       // row pair being shifted
    logic                shown;     // a row has been latched since reset

    assign scan_addr = {row, col};
    assign steal     = &subframe[STEAL_BITS-1:0];

    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            state      <= ST_FETCH;
            col        <= '0;
            row        <= '0;
            subframe   <= '0;
            shown      <= 1'b0;
            row_addr   <= '1;       // first latch then shows row 0
            blank      <= 1'b1;
            latch      <= 1'b0;
            sclk       <= 1'b0;
            rgb_top    <= 3'b000;
            rgb_bottom <= 3'b000;
        end else begin
            case (state)
                ST_FETCH: begin
                    col   <= col + 1'b1;
                    blank <= ~shown;    // dark until the first latch
                    state <= ST_SHIFT;
                end
                ST_SHIFT: begin
                    rgb_top    <= pwm_top;  // read data of the previous address
                    rgb_bottom <= pwm_bottom;
                    sclk       <= 1'b1;
                    if (col == '0) begin
                        state <= ST_LATCH;  // wrapped, column 63 went out
                    end else begin
                        col <= col + 1'b1;
                    end
                end
                ST_LATCH: begin
                    rgb_top    <= 3'b000;
                    rgb_bottom <= 3'b000;
                    sclk       <= 1'b0;
                    blank      <= 1'b1;
                    latch      <= 1'b1;
                    shown      <= 1'b1;
                    state      <= ST_UNBLANK;
                end
                ST_UNBLANK: begin
                    latch    <= 1'b0;
                    row_addr <= row;        // drive the row just latched
                    row      <= row + 1'b1;
                    if (row == ROW_BITS'(ROW_PAIRS - 1)) begin
                        subframe <= subframe + 1'b1;
                    end
                    state <= ST_FETCH;
                end
                default: state <= ST_FETCH;
            endcase
        end
    end

    // latch sits inside a blank window that outlasts it by one cycle
    a_latch_blank : assert property (@(posedge clk) disable iff (!pll_locked)
        latch |-> blank ##1 (blank && !latch && !sclk));

endmodule

// File: led_panel_top.sv
module led_panel_top #(
    parameter int STEAL_BITS = 4
) (
    input  logic                           clk,
    input  logic                           pll_locked,
    input  logic                           forward,
    input  logic                           left,
    input  logic                           right,
    output logic [2:0]                     rgb_top,
    output logic [2:0]                     rgb_bottom,
    output logic [panel_pkg::ROW_BITS-1:0] row_addr,
    output logic                           blank,
    output logic                           latch,
    output logic                           sclk
);
    import panel_pkg::*;

    logic                     steal;
    logic                     ready;
    move_cmd_e                cmd;
    logic                     wr_en;
    logic                     wr_bank;
    logic                     clear_all;
    logic [FB_ADDR_BITS-1:0]  wr_addr;
    logic [PIXEL_BITS-1:0]    wr_data;
    logic [FB_ADDR_BITS-1:0]  scan_addr;
    logic [SUBFRAME_BITS-1:0] subframe;
    logic [PIXEL_BITS-1:0]    rd_top;
    logic [PIXEL_BITS-1:0]    rd_bottom;
    logic [2:0]               pwm_top;
    logic [2:0]               pwm_bottom;

    move_decode u_decode (
        .clk(clk), .pll_locked(pll_locked),
        .forward(forward), .left(left), .right(right),
        .steal(steal), .ready(ready), .cmd(cmd)
    );

    cursor_engine u_engine (
        .clk(clk), .pll_locked(pll_locked), .steal(steal), .cmd(cmd),
        .ready(ready), .wr_en(wr_en), .wr_bank(wr_bank), .clear_all(clear_all),
        .wr_addr(wr_addr), .wr_data(wr_data)
    );

    frame_buffer u_fb (
        .clk(clk), .scan_addr(scan_addr), .rd_top(rd_top), .rd_bottom(rd_bottom),
        .wr_en(wr_en), .wr_bank(wr_bank), .clear_all(clear_all),
        .wr_addr(wr_addr), .wr_data(wr_data)
    );

    pixel_pwm u_pwm (
        .subframe(subframe), .steal(steal), .rd_top(rd_top), .rd_bottom(rd_bottom),
        .pwm_top(pwm_top), .pwm_bottom(pwm_bottom)
    );

    panel_scan #(
        .STEAL_BITS(STEAL_BITS)
    ) u_scan (
        .clk(clk), .pll_locked(pll_locked),
        .pwm_top(pwm_top), .pwm_bottom(pwm_bottom),
        .scan_addr(scan_addr), .subframe(subframe), .steal(steal),
        .rgb_top(rgb_top), .rgb_bottom(rgb_bottom), .row_addr(row_addr),
        .blank(blank), .latch(latch), .sclk(sclk)
    );

endmodule

// File: tb_panel_model.svh
`ifndef TB_PANEL_MODEL_SVH
`define TB_PANEL_MODEL_SVH

// panel image rebuilt from sclk, latch and row_addr
logic [2:0]               row_top [COLS];
logic [2:0]               row_bot [COLS];
logic [2:0]               img_top [ROW_PAIRS][COLS];
logic [2:0]               img_bot [ROW_PAIRS][COLS];
logic [ROW_BITS-1:0]      last_row;
logic [SUBFRAME_BITS-1:0] sf_cnt = '0;
int                       col_cnt = 0;
int                       latch_cnt = 0;
int                       subframes_checked = 0;
bit                       latch_seen = 1'b0;    // row_addr moves one cycle after latch
bit                       sclk_seen = 1'b0;
bit                       steal_done = 1'b0;    // first stolen subframe is over
bit                       shown_stolen = 1'b0;  // read by the stimulus

function automatic bit is_stolen(input logic [SUBFRAME_BITS-1:0] sf);
    return (sf & STEAL_MASK) == STEAL_MASK;
endfunction

// {blue, green, red} of a white or black pixel in subframe sf
function automatic logic [2:0] predict_pwm(input bit lit, input logic [SUBFRAME_BITS-1:0] sf);
    logic [SUBFRAME_BITS-1:0] rev;
    for (int i = 0; i < SUBFRAME_BITS; i++) begin
        rev[i] = sf[SUBFRAME_BITS-1-i];
    end
    if (!lit || is_stolen(sf)) begin
        return 3'b000;
    end
    return {8'hF8 > rev, 8'hFC > rev, 8'hF8 > rev};
endfunction

task automatic report_fail(input string name, input logic [31:0] got, input logic [31:0] want);
    errors++;
    $display("Fail %s: got %h expected %h", name, got, want);
endtask

task automatic check_subframe();
    logic [2:0] want;
    for (int r = 0; r < ROW_PAIRS; r++) begin
        for (int c = 0; c < COLS; c++) begin
            want = predict_pwm(exp_lit && exp_x == c && exp_y == r, sf_cnt);
            if (img_top[r][c] !== want) begin
                report_fail($sformatf("rgb_top row %h col %h", r, c), img_top[r][c], want);
            end
            // bottom half holds rows 32 to 63
            want = predict_pwm(exp_lit && exp_x == c && exp_y == r + ROW_PAIRS, sf_cnt);
            if (img_bot[r][c] !== want) begin
                report_fail($sformatf("rgb_bottom row %h col %h", r, c), img_bot[r][c], want);
            end
        end
    end
    subframes_checked++;
endtask

task automatic sample_pins();
    logic [ROW_BITS-1:0] next_row;
    if (sclk === 1'b1) begin
        sclk_seen = 1'b1;
    end
    if (!sclk_seen) begin   // idle pins until the first shift
        if (blank !== 1'b1) report_fail("blank", blank, 1);
        if (latch !== 1'b0) report_fail("latch", latch, 0);
        if (sclk !== 1'b0) report_fail("sclk", sclk, 0);
        if (rgb_top !== 3'b000) report_fail("rgb_top", rgb_top, 0);
        if (rgb_bottom !== 3'b000) report_fail("rgb_bottom", rgb_bottom, 0);
    end
    if (!pll_locked) begin
        last_row = row_addr;
    end else begin
        if (latch_seen) begin
            latch_seen = 1'b0;
            next_row   = last_row + 1'b1;
            if (row_addr !== next_row) report_fail("row_addr", row_addr, next_row);
            last_row = row_addr;
            for (int c = 0; c < COLS; c++) begin
                img_top[row_addr][c] = row_top[c];
                img_bot[row_addr][c] = row_bot[c];
            end
            latch_cnt++;
            if (latch_cnt % ROW_PAIRS == 0) begin   // subframe complete
                if (is_stolen(sf_cnt)) begin
                    steal_done = 1'b1;
                end else if (steal_done) begin
                    check_subframe();
                end
                sf_cnt = sf_cnt + 1'b1;
                shown_stolen <= is_stolen(sf_cnt);
            end
        end
        if (sclk) begin
            if (col_cnt < COLS) begin
                row_top[col_cnt] = rgb_top;
                row_bot[col_cnt] = rgb_bottom;
            end
            if (is_stolen(sf_cnt) && rgb_top !== 3'b000) report_fail("rgb_top", rgb_top, 0);
            if (is_stolen(sf_cnt) && rgb_bottom !== 3'b000) report_fail("rgb_bottom", rgb_bottom, 0);
            col_cnt++;
        end
        if (latch) begin
            if (col_cnt != COLS) report_fail("sclk count before latch", col_cnt, COLS);
            if (blank !== 1'b1) report_fail("blank at latch", blank, 1);
            col_cnt    = 0;
            latch_seen = 1'b1;
        end
    end
endtask

`endif

// File: tb_led_panel.sv
module tb_led_panel;
    import panel_pkg::*;

    localparam int STEAL_BITS  = 1;     // every second subframe stolen
    localparam int STEAL_MASK  = (1 << STEAL_BITS) - 1;
    localparam int ROW_CYCLES  = COLS + 3;  // fetch, shifts, latch, unblank
    localparam int MAX_VECTORS = 32;

    logic                clk;
    logic                pll_locked;
    logic                forward;
    logic                left;
    logic                right;
    logic [2:0]          rgb_top;
    logic [2:0]          rgb_bottom;
    logic [ROW_BITS-1:0] row_addr;
    logic                blank;
    logic                latch;
    logic                sclk;

    logic [7:0] vec_mem [4*MAX_VECTORS];    // cmd, hold, x, y per vector
    int         num_vectors = 0;
    longint     timeout_limit = 0;
    bit         vectors_ready = 1'b0;
    bit         exp_lit = 1'b0;             // cursor expected on the panel
    int         exp_x = 0;
    int         exp_y = 0;
    int         errors = 0;

    `include "tb_panel_model.svh"

    led_panel_top #(
        .STEAL_BITS(STEAL_BITS)
    ) DUT (
        .clk(clk), .pll_locked(pll_locked),
        .forward(forward), .left(left), .right(right),
        .rgb_top(rgb_top), .rgb_bottom(rgb_bottom), .row_addr(row_addr),
        .blank(blank), .latch(latch), .sclk(sclk)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        sample_pins();
    end

    task automatic load_vectors();
        int subframes;
        subframes = 8;  // startup clear and the last check
        foreach (vec_mem[i]) begin
            vec_mem[i] = 8'h00;
        end
        $readmemh("move_vectors.txt", vec_mem);
        while (num_vectors < MAX_VECTORS && vec_mem[4*num_vectors] != 8'h00) begin
            subframes += (1 << STEAL_BITS) * (vec_mem[4*num_vectors+1] + 2);
            num_vectors++;
        end
        timeout_limit = longint'(subframes) * ROW_PAIRS * ROW_CYCLES * 8;
        vectors_ready = 1'b1;
    endtask

    task automatic press_button(input logic [7:0] code);
        forward <= (code == 8'd1);
        left    <= (code == 8'd2);
        right   <= (code == 8'd3);
    endtask

    task automatic wait_steal_start();
        @(posedge clk);
        while (!shown_stolen) @(posedge clk);
    endtask

    task automatic wait_steal_end();
        @(posedge clk);
        while (shown_stolen) @(posedge clk);
    endtask

    initial begin : stimulus
        logic [7:0] hold;
        forward    = 1'b0;
        left       = 1'b0;
        right      = 1'b0;
        pll_locked = 1'b1;
        load_vectors();
        #1 pll_locked = 1'b0;
        repeat (8) @(posedge clk);
        pll_locked <= 1'b1;
        wait_steal_start();     // memory clear runs here
        wait_steal_end();
        for (int v = 0; v < num_vectors; v++) begin
            hold = vec_mem[4*v+1];
            press_button(vec_mem[4*v]);
            for (int h = 0; h < hold; h++) begin
                wait_steal_start();
                if (h == 0) begin   // the move lands in this stolen subframe
                    exp_lit <= 1'b1;
                    exp_x   <= vec_mem[4*v+2];
                    exp_y   <= vec_mem[4*v+3];
                end
                wait_steal_end();
            end
            press_button(8'h00);
            wait_steal_start();
            wait_steal_end();
        end
        wait_steal_start();
        @(posedge clk);
        if (subframes_checked == 0) begin
            errors++;
            $display("no subframe image was compared");
        end
        $display("vectors %0d subframes checked %0d latches %0d errors %0d",
                 num_vectors, subframes_checked, latch_cnt, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        wait (vectors_ready);
        #(timeout_limit);
        $display("timeout after %0d time units, the move sequence did not complete",
                 timeout_limit);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: move_vectors.txt
// cmd (1 forward, 2 left, 3 right), hold in steal periods, expected x, expected y
// a line of zeros ends the list
1 1 21 20
1 3 22 20
2 1 22 20
1 1 22 21
1 1 22 22
3 1 22 22
3 1 22 22
1 2 22 21
1 1 22 20
1 1 22 1f
3 1 22 1f
1 1 21 1f
2 1 21 1f
1 1 21 1e
2 1 21 1e
1 1 22 1e
0 0 0 0

// File: flist.f
+incdir+.
panel_pkg.sv
move_decode.sv
cursor_engine.sv
frame_buffer.sv
pixel_pwm.sv
panel_scan.sv
led_panel_top.sv
tb_led_panel.sv

// File: Bender.yml
package:
  name: led_panel

sources:
  - panel_pkg.sv
  - move_decode.sv
  - cursor_engine.sv
  - frame_buffer.sv
  - pixel_pwm.sv
  - panel_scan.sv
  - led_panel_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_led_panel.sv
